// File: hdl/byte_packer.sv
/*
 * Byte packer
 * Decodes the region of each byte and builds big-endian words:
 * 32-bit graphics words to a stallable port, 16-bit program words to the banks
 */
`timescale 1ns/1ps
`default_nettype none

module byte_packer import rom_load_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	load_byte_if.packer bus,
	output logic        mem_valid,
	output gfx_addr_t   mem_addr,
	output gfx_word_t   mem_data,
	input  logic        mem_ready,
	output logic        bank_we,
	output prog_addr_t  bank_waddr,
	output prog_word_t  bank_wdata
);

	logic [23:0] acc;  // Last three bytes, oldest on top
	logic        is_gfx, is_bank_a, is_bank_b;
	logic        gfx_last, prog_last;
	byte_addr_t  gfx_off, prog_off;
	prog_addr_t  word_base;

	// ##################################################
	// Region decode
	// ##################################################
	assign is_gfx    = (bus.addr <= GFX_END);
	assign is_bank_a = (bus.addr >= BANK_A_BASE) &&
		(bus.addr < byte_addr_t'(BANK_A_BASE + BANK_BYTES));
	assign is_bank_b = (bus.addr >= BANK_B_BASE) &&
		(bus.addr < byte_addr_t'(BANK_B_BASE + BANK_BYTES));

	assign gfx_off   = bus.addr - GFX_BASE;
	assign prog_off  = bus.addr - (is_bank_b ? BANK_B_BASE : BANK_A_BASE);
	assign word_base = is_bank_b ? BANK_B_WORD : BANK_A_WORD;

	// Fourth byte of a graphics word, second byte of a program word
	assign gfx_last  = bus.fire && is_gfx && (bus.addr[1:0] == 2'b11);
	assign prog_last = bus.fire && (is_bank_a || is_bank_b) && bus.addr[0];

	// Hold the stream while a word sits at the port
	assign bus.busy = mem_valid;

	// ##################################################
	// Control
	// ##################################################
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mem_valid <= 1'b0;
			bank_we   <= 1'b0;
		end else begin
			bank_we <= prog_last;
			if (gfx_last)
				mem_valid <= 1'b1;
			else if (mem_ready)
				mem_valid <= 1'b0;  // Handshake done
		end
	end

	// Payload, filler bytes just pass through acc
	always_ff @(posedge clk_sys) begin
		if (bus.fire)
			acc <= {acc[15:0], bus.data};
		if (gfx_last) begin
			mem_addr <= gfx_off[9:2];
			mem_data <= {acc, bus.data};  // First byte ends up in [31:24]
		end
		if (prog_last) begin
			bank_waddr <= word_base + {2'b00, prog_off[8:1]};
			bank_wdata <= {acc[7:0], bus.data};
		end
	end

endmodule

`default_nettype wire

// File: hdl/load_byte_if.sv
/*
 * Accepted-byte channel
 * One pulse per byte with its image address, plus packer back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

interface load_byte_if import rom_load_pkg::*; ();

	logic       fire;  // One cycle per accepted byte
	byte_addr_t addr;  // Image address of that byte
	load_byte_t data;
	logic       busy;  // Graphics word still waiting at the memory port

	// Sequencer side, hands bytes over
	modport sequencer (
		output fire,
		output addr,
		output data,
		input  busy
	);

	// Packer side, may hold off the stream
	modport packer (
		input  fire,
		input  addr,
		input  data,
		output busy
	);

endinterface

`default_nettype wire

// File: hdl/load_counter.sv
/*
 * Image byte counter
 * Counts accepted bytes to form the image address
 */
`timescale 1ns/1ps
`default_nettype none

module load_counter import rom_load_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       clear,    // Start of a download
	input  logic       incr,     // Byte accepted
	output byte_addr_t count,
	output logic       at_last
);

	// Last image byte sits at IMAGE_BYTES-1
	assign at_last = (count == byte_addr_t'(IMAGE_BYTES - 1));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (incr) begin
			count <= count + 1'b1;  // Visible the clock after the byte
		end
	end

endmodule

`default_nettype wire

// File: hdl/load_sequencer.sv
/*
 * Download sequencer
 * Runs one image download, gates the stream handshake and flags completion
 */
`timescale 1ns/1ps
`default_nettype none

module load_sequencer import rom_load_pkg::*; (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  logic           dl_active,
	input  logic           dl_valid,
	input  load_byte_t     dl_data,
	output logic           dl_ready,
	input  byte_addr_t     count,     // Address of the next byte
	input  logic           at_last,   // Next byte closes the image
	output logic           cnt_clear,
	output logic           loaded,
	load_byte_if.sequencer bus
);

	load_state_t state, state_nxt;
	logic        active_q;  // dl_active delayed, for rise detect in ST_DONE
	logic        start;

	// Level start from idle, fresh rise needed once done
	assign start = dl_active &&
		((state == ST_IDLE) || ((state == ST_DONE) && !active_q));

	assign dl_ready  = (state == ST_RECEIVE) && dl_active && !bus.busy;
	assign bus.fire  = dl_ready && dl_valid;  // Byte transfers here
	assign bus.addr  = count;
	assign bus.data  = dl_data;
	assign cnt_clear = start;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE, ST_DONE: begin
				if (start)
					state_nxt = ST_RECEIVE;
			end
			ST_RECEIVE: begin
				if (!dl_active)
					state_nxt = ST_IDLE;  // Aborted mid-image
				else if (bus.fire && at_last)
					state_nxt = ST_DRAIN;
			end
			ST_DRAIN: begin
				if (!dl_active)
					state_nxt = ST_IDLE;
				else if (!bus.busy)
					state_nxt = ST_DONE;  // Nothing left at the port
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			active_q <= 1'b0;
			loaded   <= 1'b0;
		end else begin
			state    <= state_nxt;
			active_q <= dl_active;
			if (start)
				loaded <= 1'b0;  // New download invalidates the image
			else if ((state == ST_DRAIN) && (state_nxt == ST_DONE))
				loaded <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/prog_rom_banks.sv
/*
 * Program ROM banks
 * Two 256-word banks, written by the loader, read with one clock latency
 * Holes and addresses past bank B read as zero
 */
`timescale 1ns/1ps
`default_nettype none

module prog_rom_banks import rom_load_pkg::*; (
	input  logic       clk_sys,
	input  logic       we,
	input  prog_addr_t waddr,
	input  prog_word_t wdata,
	input  prog_addr_t rd_addr,
	output prog_word_t rd_data
);

	prog_word_t bank_a [BANK_WORDS];
	prog_word_t bank_b [BANK_WORDS];

	logic [7:0] widx, ridx;  // Word index inside a bank
	logic       we_a, we_b;
	logic       rd_a, rd_b;
	prog_word_t rd_q;
	logic       hit_q;       // Read address landed in a bank

	assign widx = waddr[7:0];
	assign ridx = rd_addr[7:0];

	// Bank select from the upper word-address bits
	assign we_a = we && (waddr[9:8] == BANK_A_WORD[9:8]);
	assign we_b = we && (waddr[9:8] == BANK_B_WORD[9:8]);
	assign rd_a = (rd_addr[9:8] == BANK_A_WORD[9:8]);
	assign rd_b = (rd_addr[9:8] == BANK_B_WORD[9:8]);

	// ##################################################
	// Write port
	// ##################################################
	always_ff @(posedge clk_sys) begin
		if (we_a)
			bank_a[widx] <= wdata;
		if (we_b)
			bank_b[widx] <= wdata;
	end

	// ##################################################
	// Read port
	// ##################################################
	always_ff @(posedge clk_sys) begin
		rd_q  <= rd_b ? bank_b[ridx] : bank_a[ridx];
		hit_q <= rd_a || rd_b;  // Travels with the data
	end

	// Miss reads zero
	assign rd_data = hit_q ? rd_q : '0;

endmodule

`default_nettype wire

// File: hdl/rom_load_pkg.sv
/*
 * ROM loader shared definitions
 * Image address map, data widths and the download FSM states
 */
`default_nettype none

package rom_load_pkg;

	// ##################################################
	// Widths
	// ##################################################
	typedef logic [11:0] byte_addr_t;  // Image byte address
	typedef logic [9:0]  prog_addr_t;  // Program word address
	typedef logic [7:0]  gfx_addr_t;   // Graphics word index
	typedef logic [7:0]  load_byte_t;  // One download byte
	typedef logic [15:0] prog_word_t;  // Program word
	typedef logic [31:0] gfx_word_t;   // Graphics word

	// ##################################################
	// Image map, scaled down for short simulation
	// ##################################################
	localparam int IMAGE_BYTES = 2560;  // Whole image, last byte at 0x9FF

	localparam byte_addr_t GFX_BASE = 12'h000;  // Graphics, 256 words of 4 bytes
	localparam byte_addr_t GFX_END  = 12'h3FF;

	localparam byte_addr_t BANK_A_BASE = 12'h400;  // Program bank A
	localparam byte_addr_t BANK_B_BASE = 12'h800;  // Bank B, filler sits in between
	localparam int         BANK_BYTES  = 512;
	localparam int         BANK_WORDS  = 256;

	// Word addresses seen on the program read port
	localparam prog_addr_t BANK_A_WORD = 10'h000;
	localparam prog_addr_t BANK_B_WORD = 10'h200;

	// Download FSM
	typedef enum logic [1:0] {
		ST_IDLE,     // Waiting for dl_active
		ST_RECEIVE,  // Taking bytes
		ST_DRAIN,    // Last graphics word still at the port
		ST_DONE      // Image complete
	} load_state_t;

endpackage

`default_nettype wire

// File: hdl/rom_loader_top.sv
/*
 * ROM loader top level
 * Byte stream in, graphics words out to memory, program words to on-chip banks
 */
`timescale 1ns/1ps
`default_nettype none

module rom_loader_top import rom_load_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	// Download stream
	input  logic       dl_active,
	input  logic       dl_valid,
	input  load_byte_t dl_data,
	output logic       dl_ready,
	// Graphics memory port
	output logic       mem_valid,
	output gfx_addr_t  mem_addr,
	output gfx_word_t  mem_data,
	input  logic       mem_ready,
	// Program read
	input  prog_addr_t prog_rd_addr,
	output prog_word_t prog_rd_data,
	// Status
	output logic       loaded
);

	byte_addr_t count;
	logic       at_last;
	logic       cnt_clear;
	logic       bank_we;
	prog_addr_t bank_waddr;
	prog_word_t bank_wdata;

	load_byte_if load_bus ();  // Accepted bytes, sequencer to packer

	load_sequencer seq_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.dl_active (dl_active),
		.dl_valid  (dl_valid),
		.dl_data   (dl_data),
		.dl_ready  (dl_ready),
		.count     (count),
		.at_last   (at_last),
		.cnt_clear (cnt_clear),
		.loaded    (loaded),
		.bus       (load_bus.sequencer)
	);

	load_counter cnt_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.clear   (cnt_clear),
		.incr    (load_bus.fire),  // One step per accepted byte
		.count   (count),
		.at_last (at_last)
	);

	byte_packer pack_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.bus        (load_bus.packer),
		.mem_valid  (mem_valid),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.mem_ready  (mem_ready),
		.bank_we    (bank_we),
		.bank_waddr (bank_waddr),
		.bank_wdata (bank_wdata)
	);

	prog_rom_banks banks_i (
		.clk_sys (clk_sys),
		.we      (bank_we),
		.waddr   (bank_waddr),
		.wdata   (bank_wdata),
		.rd_addr (prog_rd_addr),
		.rd_data (prog_rd_data)
	);

endmodule

`default_nettype wire

// File: list.f
hdl/rom_load_pkg.sv
hdl/load_byte_if.sv
hdl/load_sequencer.sv
hdl/load_counter.sv
hdl/byte_packer.sv
hdl/prog_rom_banks.sv
hdl/rom_loader_top.sv
verification/tb_rom_loader.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ROM loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_rom_loader
LOG=sim.log

verilator --binary --timing -Wno-fatal -j 0 --top-module "$TOP" -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: verification/tb_rom_loader.sv
/*
 * ROM loader testbench
 * Directed loads of an xorshift image, graphics memory model with stalls,
 * program readback, completion and abort handling
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rom_loader import rom_load_pkg::*; ();

	localparam int CLK_PERIOD   = 20;
	localparam int NUM_TESTS    = 5;
	localparam int STALL_MARGIN = 8;  // Cycles per byte, worst case with gaps
	localparam int WATCHDOG_NS  = IMAGE_BYTES * NUM_TESTS * STALL_MARGIN * CLK_PERIOD;
	localparam int GFX_WORDS    = (int'(GFX_END) - int'(GFX_BASE) + 1) / 4;
	localparam int PROG_SPAN    = 1 << $bits(prog_addr_t);  // Whole read space
	localparam logic [31:0] SEED = 32'h7db1_0969;

	logic       clk_sys, rst_n;
	logic       dl_active, dl_valid, dl_ready;
	load_byte_t dl_data;
	logic       mem_valid, mem_ready;
	gfx_addr_t  mem_addr;
	gfx_word_t  mem_data;
	prog_addr_t prog_rd_addr;
	prog_word_t prog_rd_data;
	logic       loaded;

	load_byte_t  image [IMAGE_BYTES];  // Reference image
	logic [31:0] rng_stream, rng_mem;
	logic        mem_stall;            // Memory model drops ready at random
	gfx_word_t   gfx_words [$];        // Words taken by the memory model
	gfx_addr_t   gfx_addrs [$];
	int          n_checks, n_errors;

	rom_loader_top dut_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl_active    (dl_active),
		.dl_valid     (dl_valid),
		.dl_data      (dl_data),
		.dl_ready     (dl_ready),
		.mem_valid    (mem_valid),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.mem_ready    (mem_ready),
		.prog_rd_addr (prog_rd_addr),
		.prog_rd_data (prog_rd_data),
		.loaded       (loaded)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ##################################################
	// Helpers
	// ##################################################
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Program word from the map, big-endian byte pair
	function automatic prog_word_t exp_prog_word(input prog_addr_t a);
		int w;
		int off;
		w = int'(a);
		if (w >= int'(BANK_A_WORD) && w < int'(BANK_A_WORD) + BANK_WORDS)
			off = int'(BANK_A_BASE) + 2 * (w - int'(BANK_A_WORD));
		else if (w >= int'(BANK_B_WORD) && w < int'(BANK_B_WORD) + BANK_WORDS)
			off = int'(BANK_B_BASE) + 2 * (w - int'(BANK_B_WORD));
		else
			return '0;  // Hole or past bank B
		return {image[off], image[off + 1]};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic fill_image();
		for (int i = 0; i < IMAGE_BYTES; i++) begin
			rng_stream = xorshift(rng_stream);
			image[i]   = rng_stream[7:0];
		end
	endtask

	// Streams n_bytes of the image, aborts when short of a full image
	task automatic load_image(input int n_bytes, input logic stall);
		int   sent;
		int   idle;
		logic pending;  // Offered byte not yet taken
		mem_stall = stall;
		gfx_words.delete();
		gfx_addrs.delete();
		dl_active = 1'b0;
		dl_valid  = 1'b0;
		repeat (2) @(negedge clk_sys);  // Fresh rise after a finished load
		dl_active = 1'b1;
		@(negedge clk_sys);
		sent    = 0;
		pending = 1'b0;
		while (sent < n_bytes) begin
			if (!pending) begin
				rng_stream = xorshift(rng_stream);
				dl_valid   = (rng_stream[1:0] != 2'b00);  // About one gap in four
				dl_data    = image[sent];
			end
			#1;
			check("dl_ready with mem_valid", 32'h0, 32'(dl_ready && mem_valid));
			check("loaded", 32'h0, 32'(loaded));  // Not before the last byte
			pending = dl_valid && !dl_ready;      // Source holds the byte
			if (dl_valid && dl_ready)
				sent++;
			@(negedge clk_sys);
		end
		dl_valid = 1'b0;
		if (n_bytes < IMAGE_BYTES) begin
			dl_active = 1'b0;  // Abort mid-image
			repeat (4) @(negedge clk_sys);
			check("loaded", 32'h0, 32'(loaded));
		end else begin
			idle = 0;
			while (!loaded && idle < 1000) begin
				@(negedge clk_sys);
				idle++;
			end
			if (!loaded) begin
				n_errors++;
				$display("At %0t loaded never rose after the last byte", $time);
			end
		end
	endtask

	task automatic check_gfx_words();
		int b;
		check("graphics word count", 32'(GFX_WORDS), 32'(gfx_words.size()));
		for (int i = 0; i < gfx_words.size() && i < GFX_WORDS; i++) begin
			b = int'(GFX_BASE) + 4 * i;  // First byte lands on top
			check($sformatf("mem_addr[%0d]", i), 32'(i), 32'(gfx_addrs[i]));
			check($sformatf("mem_data[%0d]", i),
				{image[b], image[b + 1], image[b + 2], image[b + 3]}, gfx_words[i]);
		end
	endtask

	// One address per clock, data checked one clock later
	task automatic read_program();
		prog_addr_t prev;
		prev = '0;
		for (int a = 0; a <= PROG_SPAN; a++) begin
			@(negedge clk_sys);
			if (a > 0)
				check($sformatf("prog_rd_data@%h", prev), 32'(exp_prog_word(prev)),
					32'(prog_rd_data));
			if (a < PROG_SPAN) begin
				prog_rd_addr = prog_addr_t'(a);
				prev         = prog_addr_t'(a);
			end
		end
	endtask

	// ##################################################
	// Tests
	// ##################################################
	task automatic test_gfx_no_stall();
		$display("Test: graphics words, ready held high");
		load_image(IMAGE_BYTES, 1'b0);
		check_gfx_words();
	endtask

	task automatic test_back_pressure();
		$display("Test: graphics words under back-pressure");
		fill_image();
		load_image(IMAGE_BYTES, 1'b1);
		check_gfx_words();
	endtask

	task automatic test_program_readback();
		$display("Test: program bank readback");
		read_program();  // Image of the previous load
	endtask

	task automatic test_completion();
		$display("Test: completion and idle stream");
		fill_image();
		load_image(IMAGE_BYTES, 1'b0);
		check("loaded", 32'h1, 32'(loaded));
		dl_valid = 1'b1;  // Source keeps offering
		repeat (20) begin
			#1;
			check("dl_ready after loaded", 32'h0, 32'(dl_ready));
			check("loaded", 32'h1, 32'(loaded));
			@(negedge clk_sys);
		end
		dl_valid = 1'b0;
	endtask

	task automatic test_abort_reload();
		$display("Test: abort and reload");
		fill_image();
		load_image(1200, 1'b1);  // Stops inside bank A
		fill_image();
		load_image(IMAGE_BYTES, 1'b1);
		check_gfx_words();
		read_program();
	endtask

	// ##################################################
	// Memory side model
	// ##################################################
	initial begin
		rng_mem   = xorshift(~SEED);
		mem_ready = 1'b0;
		forever begin
			@(negedge clk_sys);
			rng_mem   = xorshift(rng_mem);
			mem_ready = !mem_stall || rng_mem[0];
			#1;
			if (mem_valid && mem_ready) begin  // Word taken at next edge
				gfx_words.push_back(mem_data);
				gfx_addrs.push_back(mem_addr);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, n_errors);
		$display("TEST FAILED");
		$finish;
	end

	// ##################################################
	// Main sequence
	// ##################################################
	initial begin
		rst_n        = 1'b0;
		dl_active    = 1'b0;
		dl_valid     = 1'b0;
		dl_data      = '0;
		prog_rd_addr = '0;
		mem_stall    = 1'b0;
		n_checks     = 0;
		n_errors     = 0;
		rng_stream   = SEED;
		repeat (10) @(negedge clk_sys);
		check("dl_ready in reset", 32'h0, 32'(dl_ready));
		check("mem_valid in reset", 32'h0, 32'(mem_valid));
		check("loaded in reset", 32'h0, 32'(loaded));
		rst_n = 1'b1;
		fill_image();
		test_gfx_no_stall();
		test_back_pressure();
		test_program_readback();
		test_completion();
		test_abort_reload();
		$display("Done: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
